// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= div_unit_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the log decides the outcome, an assertion stop leaves no pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/div_unit_checker.sv ====
module div_unit_checker
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic ready,
	input logic exec_busy,
	input logic result_valid,
	input logic div_zero,
	input logic illegal_op
);

	// sampled one edge after the registering edge
	localparam int lag = div_pkg::exec_latency + 1;

	logic accepted;

	assign accepted = start & ready;

	// single cycle pulse
	assert property (@(posedge clk) disable iff (!rst_n) result_valid |=> !result_valid)
		else $error("result_valid stayed high for more than one cycle");

	// fixed latency in both directions
	assert property (@(posedge clk) disable iff (!rst_n) $past(accepted, lag) |-> result_valid)
		else $error("no result_valid at the fixed latency after an accepted command");
	assert property (@(posedge clk) disable iff (!rst_n) result_valid |-> $past(accepted, lag))
		else $error("result_valid without an accepted command at the fixed latency");

	// ready stays down through the whole execution
	assert property (@(posedge clk) disable iff (!rst_n) exec_busy |-> !ready)
		else $error("ready was high while the divider was busy");
	assert property (@(posedge clk) disable iff (!rst_n) result_valid |-> ready)
		else $error("ready did not return together with result_valid");

	// flags only travel with a result
	assert property (@(posedge clk) disable iff (!rst_n) (div_zero | illegal_op) |-> result_valid)
		else $error("error flag high without result_valid");

endmodule

bind div_unit_top div_unit_checker u_checker
(
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.ready(ready),
	.exec_busy(exec_busy),
	.result_valid(result_valid),
	.div_zero(div_zero),
	.illegal_op(illegal_op)
);

// ==== bench/div_unit_monitor.sv ====
module div_unit_monitor
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic ready,
	input logic [1:0] op,
	input logic [div_pkg::dividend_width-1:0] dividend,
	input logic [div_pkg::divisor_width-1:0] divisor,
	input logic result_valid,
	input logic [div_pkg::dividend_width-1:0] quotient,
	input logic [div_pkg::divisor_width-1:0] remainder,
	input logic div_zero,
	input logic illegal_op,
	input logic [8*24-1:0] test_name,
	output int pass_count,
	output int fail_count,
	output int pending
);

	// expected {quotient, remainder, div_zero, illegal_op}, oldest first
	logic [25:0] exp_q [$];
	logic [8*24-1:0] name_q [$];
	int passes = 0;
	int fails = 0;
	int outstanding = 0;

	assign pass_count = passes;
	assign fail_count = fails;
	assign pending = outstanding;

	// reference model of one command
	function automatic logic [25:0] model(input logic [1:0] op_v, input logic [15:0] dvd,
		input logic [7:0] dvs);
		logic [15:0] q;
		logic [15:0] r;
		logic dz;
		logic ill;
		dz = (dvs == 8'd0);
		ill = (op_v == div_pkg::op_illegal);
		q = '0;
		r = '0;
		// errors give zeros, otherwise op picks the halves
		if (!dz && !ill)
		begin
			if (op_v != div_pkg::op_rem)
				q = dvd / {8'd0, dvs};
			if (op_v != div_pkg::op_quot)
				r = dvd % {8'd0, dvs};
		end
		return {q, r[7:0], dz, ill};
	endfunction

	// one packed result as readable fields
	function automatic string format_result(input logic [25:0] v);
		return $sformatf("q=%0d r=%0d dz=%b ill=%b", v[25:10], v[9:2], v[1], v[0]);
	endfunction

	// mid cycle, inputs and outputs are settled here
	always @(negedge clk)
	begin : sample
		logic [25:0] exp_v;
		logic [25:0] act_v;
		logic [8*24-1:0] nm;
		if (rst_n)
		begin
			if (result_valid)
			begin
				act_v = {quotient, remainder, div_zero, illegal_op};
				if (exp_q.size() == 0)
				begin
					$display("result_valid came without any accepted command");
					fails++;
				end
				else
				begin
					exp_v = exp_q.pop_front();
					nm = name_q.pop_front();
					if (act_v == exp_v)
					begin
						$display("Pass %0s", nm);
						passes++;
					end
					else
					begin
						$display("Fail %0s: expected %s, actual %s",
							nm, format_result(exp_v), format_result(act_v));
						fails++;
					end
				end
			end
			// accepted at the coming edge
			if (start && ready)
			begin
				exp_q.push_back(model(op, dividend, divisor));
				name_q.push_back(test_name);
			end
			outstanding = exp_q.size();
		end
	end

endmodule

// ==== bench/div_unit_tb.sv ====
module div_unit_tb;

	localparam int half_period = 50;
	localparam int drive_delay = 5;
	localparam int wait_limit = 40;
	localparam int random_count = 20;

	logic clk;
	logic rst_n;
	logic start;
	logic [1:0] op;
	logic [15:0] dividend;
	logic [7:0] divisor;
	logic ready;
	logic result_valid;
	logic [15:0] quotient;
	logic [7:0] remainder;
	logic div_zero;
	logic illegal_op;
	logic [8*24-1:0] test_name;
	int pass_count;
	int fail_count;
	int pending;
	int tb_passes;
	int tb_fails;
	logic aborted;
	logic [31:0] lcg_state;

	always #half_period clk = ~clk;

	div_unit_top DUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.dividend(dividend),
		.divisor(divisor),
		.ready(ready),
		.result_valid(result_valid),
		.quotient(quotient),
		.remainder(remainder),
		.div_zero(div_zero),
		.illegal_op(illegal_op)
	);

	div_unit_monitor mon
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.ready(ready),
		.op(op),
		.dividend(dividend),
		.divisor(divisor),
		.result_valid(result_valid),
		.quotient(quotient),
		.remainder(remainder),
		.div_zero(div_zero),
		.illegal_op(illegal_op),
		.test_name(test_name),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.pending(pending)
	);

	// lcg step, numerical recipes constants
	function automatic logic [31:0] lcg_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// drive point of the next cycle
	task automatic next_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready && n < wait_limit)
		begin
			next_cycle();
			n++;
		end
		if (!ready)
		begin
			$display("Timeout in %0s: ready stayed low for %0d cycles",
				test_name, wait_limit);
			tb_fails++;
			aborted = 1'b1;
		end
	endtask

	// at least one edge, the result can't come earlier
	task automatic wait_result();
		int n;
		n = 0;
		do
		begin
			next_cycle();
			n++;
		end
		while (!result_valid && n < wait_limit);
		if (!result_valid)
		begin
			$display("Timeout in %0s: no result_valid within %0d cycles",
				test_name, wait_limit);
			tb_fails++;
			aborted = 1'b1;
		end
	endtask

	// the monitor compares at the falling edge after result_valid
	task automatic wait_drain();
		int n;
		n = 0;
		while (pending != 0 && n < wait_limit)
		begin
			next_cycle();
			n++;
		end
	endtask

	// one cycle start strobe once ready
	task automatic send(input logic [1:0] op_v, input logic [15:0] dvd, input logic [7:0] dvs);
		if (aborted)
			return;
		wait_ready();
		if (aborted)
			return;
		op = op_v;
		dividend = dvd;
		divisor = dvs;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
	endtask

	task automatic run_one(input logic [8*24-1:0] name, input logic [1:0] op_v,
		input logic [15:0] dvd, input logic [7:0] dvs);
		test_name = name;
		send(op_v, dvd, dvs);
		if (!aborted)
			wait_result();
	endtask

	initial
	begin
		logic [31:0] r;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		op = 2'd0;
		dividend = '0;
		divisor = '0;
		test_name = "reset_state";
		tb_passes = 0;
		tb_fails = 0;
		aborted = 1'b0;
		lcg_state = 32'h4ffb;
		repeat (2) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;

		// idle state straight out of reset
		if (ready && !result_valid && quotient == '0 && remainder == '0
			&& !div_zero && !illegal_op)
		begin
			$display("Pass reset_state");
			tb_passes++;
		end
		else
		begin
			$display("Fail reset_state: expected ready=1 rv=0 q=0 r=0 dz=0 ill=0, actual %s",
				$sformatf("ready=%b rv=%b q=%0d r=%0d dz=%b ill=%b",
					ready, result_valid, quotient, remainder, div_zero, illegal_op));
			tb_fails++;
		end

		for (int i = 0; i < random_count; i++)
		begin
			r = lcg_rand();
			run_one("quot_random", div_pkg::op_quot, r[31:16], r[15:8]);
		end

		for (int i = 0; i < random_count; i++)
		begin
			r = lcg_rand();
			run_one("rem_both_random", r[28] ? div_pkg::op_both : div_pkg::op_rem,
				r[31:16], r[15:8]);
		end
		// extremes of both operands
		run_one("rem_max_by_1", div_pkg::op_rem, 16'hffff, 8'd1);
		run_one("both_max_by_1", div_pkg::op_both, 16'hffff, 8'd1);
		run_one("rem_max_by_255", div_pkg::op_rem, 16'hffff, 8'd255);
		run_one("both_max_by_255", div_pkg::op_both, 16'hffff, 8'd255);
		run_one("both_254_by_255", div_pkg::op_both, 16'd254, 8'd255);

		for (int k = 0; k < 3; k++)
		begin
			r = lcg_rand();
			run_one("zero_divisor", 2'(k), r[31:16], 8'd0);
		end

		for (int i = 0; i < 4; i++)
		begin
			r = lcg_rand();
			run_one("illegal_op", div_pkg::op_illegal, r[31:16], r[15:8]);
		end
		// both flags together
		run_one("illegal_zero_divisor", div_pkg::op_illegal, 16'd77, 8'd0);

		// second strobe lands while ready is low
		test_name = "busy_strobe";
		send(div_pkg::op_both, 16'd1000, 8'd7);
		if (!aborted)
		begin
			next_cycle();
			op = div_pkg::op_quot;
			dividend = 16'hffff;
			divisor = 8'd3;
			start = 1'b1;
			next_cycle();
			start = 1'b0;
			wait_result();
			if (!aborted && !ready)
			begin
				$display("ready was still low when result_valid came up");
				tb_fails++;
			end
			// quiet period, a stray result shows in the monitor
			repeat (10) next_cycle();
		end

		// each issued on the first ready cycle
		for (int i = 0; i < 12; i++)
		begin
			r = lcg_rand();
			run_one("back_to_back", r[17:16], r[31:16], r[15:8]);
		end

		wait_drain();
		if (pending != 0)
		begin
			$display("%0d accepted commands never produced a result", pending);
			tb_fails++;
		end
		$display("Tests passed: %0d, failed: %0d",
			pass_count + tb_passes, fail_count + tb_fails);
		if (fail_count == 0 && tb_fails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
design/div_pkg.sv
design/div_ifs.sv
design/div_decode.sv
design/div_execute.sv
design/div_result.sv
design/div_unit_top.sv
bench/div_unit_checker.sv
bench/div_unit_monitor.sv
bench/div_unit_tb.sv

// ==== design/div_decode.sv ====
module div_decode
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [1:0] op,
	input logic [div_pkg::dividend_width-1:0] dividend,
	input logic [div_pkg::divisor_width-1:0] divisor,
	input logic busy,
	div_cmd_if.decode_mp cmd
);

	logic accept;
	logic zero_div;
	logic bad_op;
	div_pkg::div_op_e op_in;

	// strobes while busy are dropped here
	assign accept = start & ~busy;

	assign op_in = div_pkg::div_op_e'(op);

	// error checks on the raw command
	assign zero_div = (divisor == '0);
	assign bad_op = (op_in == div_pkg::op_illegal);

	// load strobe, one cycle after the accepting edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd.load <= 1'b0;
		end
		else
		begin
			cmd.load <= accept;
		end
	end

	// command capture
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd.op <= op_in;
			cmd.div_zero <= zero_div;
			cmd.illegal <= bad_op;

			// 0 / 1 keeps execute on a well defined zero result
			if (zero_div || bad_op)
			begin
				cmd.dividend <= '0;
				cmd.divisor <= div_pkg::divisor_width'(1);
			end
			else
			begin
				cmd.dividend <= dividend;
				cmd.divisor <= divisor;
			end
		end
	end

endmodule

// ==== design/div_execute.sv ====
module div_execute
(
	input logic clk,
	input logic rst_n,
	div_cmd_if.execute_mp cmd,
	div_res_if.execute_mp res,
	output logic busy
);

	div_pkg::div_state_e state_q;
	div_pkg::div_state_e phase;

	// multiples 0 to 15 of the divisor
	logic [div_pkg::partial_width-1:0] mult_q [div_pkg::table_size];

	// dividend shifts left one nibble per digit
	logic [div_pkg::dividend_width-1:0] dvd_q;
	logic [div_pkg::dividend_width-1:0] quo_q;
	logic [div_pkg::divisor_width-1:0] rem_q;
	logic [div_pkg::count_width-1:0] cnt_q;

	div_pkg::div_op_e op_q;
	logic zero_q;
	logic illegal_q;
	logic done_q;

	logic [div_pkg::partial_width-1:0] partial;
	logic [div_pkg::partial_width-1:0] diff;
	logic [div_pkg::digit_width-1:0] digit;
	logic [div_pkg::digit_width-1:0] trial;
	logic last;

	// load marks the table cycle
	assign phase = cmd.load ? div_pkg::st_table : state_q;

	assign last = (cnt_q == div_pkg::count_width'(div_pkg::num_digits - 1));

	// old remainder with the next dividend nibble appended
	assign partial = {rem_q, dvd_q[div_pkg::dividend_width-1 -: div_pkg::digit_width]};

	// binary search, msb of the digit first
	// keeps each trial bit whose multiple still fits
	always_comb
	begin
		digit = '0;
		trial = '0;
		for (int lvl = div_pkg::digit_width - 1; lvl >= 0; lvl--)
		begin
			trial = digit;
			trial[lvl] = 1'b1;
			if (mult_q[trial] <= partial)
			begin
				digit = trial;
			end
		end
	end

	// always below the divisor, so it fits the remainder width
	assign diff = partial - mult_q[digit];

	// control
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= div_pkg::st_idle;
			cnt_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (phase)
				div_pkg::st_table:
				begin
					state_q <= div_pkg::st_work;
					cnt_q <= '0;
				end

				div_pkg::st_work:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (last)
					begin
						state_q <= div_pkg::st_idle;
						done_q <= 1'b1;
					end
				end

				default:
				begin
					state_q <= div_pkg::st_idle;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk)
	begin
		if (phase == div_pkg::st_table)
		begin
			for (int k = 0; k < div_pkg::table_size; k++)
			begin
				mult_q[k] <= div_pkg::partial_width'(cmd.divisor)
					* div_pkg::partial_width'(k);
			end
			dvd_q <= cmd.dividend;
			rem_q <= '0;
			op_q <= cmd.op;
			zero_q <= cmd.div_zero;
			illegal_q <= cmd.illegal;
		end
		else if (phase == div_pkg::st_work)
		begin
			dvd_q <= dvd_q << div_pkg::digit_width;
			quo_q <= {quo_q[div_pkg::dividend_width-div_pkg::digit_width-1:0], digit};
			rem_q <= diff[div_pkg::divisor_width-1:0];
		end
	end

	// working registers hold the final values while done is high
	assign res.done = done_q;
	assign res.quotient = quo_q;
	assign res.remainder = rem_q;
	assign res.op = op_q;
	assign res.div_zero = zero_q;
	assign res.illegal = illegal_q;

	// from load through the done cycle
	assign busy = (phase != div_pkg::st_idle) | done_q;

endmodule

// ==== design/div_ifs.sv ====
// decode to execute
// load is a one-cycle strobe, the rest is valid with it
interface div_cmd_if;
	logic load;
	logic [div_pkg::dividend_width-1:0] dividend;
	logic [div_pkg::divisor_width-1:0] divisor;
	div_pkg::div_op_e op;
	logic div_zero;
	logic illegal;

	modport decode_mp
	(
		output load,
		output dividend,
		output divisor,
		output op,
		output div_zero,
		output illegal
	);

	modport execute_mp
	(
		input load,
		input dividend,
		input divisor,
		input op,
		input div_zero,
		input illegal
	);
endinterface

// execute to result
// done is a one-cycle strobe, the rest is valid with it
interface div_res_if;
	logic done;
	logic [div_pkg::dividend_width-1:0] quotient;
	logic [div_pkg::divisor_width-1:0] remainder;
	div_pkg::div_op_e op;
	logic div_zero;
	logic illegal;

	modport execute_mp
	(
		output done,
		output quotient,
		output remainder,
		output op,
		output div_zero,
		output illegal
	);

	modport result_mp
	(
		input done,
		input quotient,
		input remainder,
		input op,
		input div_zero,
		input illegal
	);
endinterface

// ==== design/div_pkg.sv ====
package div_pkg;

	// operand widths
	// quotient is as wide as the dividend, remainder as wide as the divisor
	localparam int dividend_width = 16;
	localparam int divisor_width = 8;

	// radix-16 long division, one nibble per iteration
	localparam int digit_width = 4;
	localparam int num_digits = 4;

	// partial remainder holds the previous remainder plus one new nibble
	localparam int partial_width = divisor_width + digit_width;

	// one multiple of the divisor per possible digit value
	localparam int table_size = 1 << digit_width;

	// iteration counter width
	localparam int count_width = $clog2(num_digits);

	// accepting edge to result strobe, in cycles
	localparam int exec_latency = 6;

	// command opcodes
	typedef enum logic [1:0]
	{
		op_quot = 2'd0,
		op_rem = 2'd1,
		op_both = 2'd2,
		op_illegal = 2'd3
	} div_op_e;

	// execute stage states
	// st_table is only seen while load is high
	typedef enum logic [1:0]
	{
		st_idle = 2'd0,
		st_table = 2'd1,
		st_work = 2'd2
	} div_state_e;

endpackage

// ==== design/div_result.sv ====
module div_result
(
	input logic clk,
	input logic rst_n,
	div_res_if.result_mp res,
	output logic result_valid,
	output logic [div_pkg::dividend_width-1:0] quotient,
	output logic [div_pkg::divisor_width-1:0] remainder,
	output logic div_zero,
	output logic illegal_op
);

	logic keep_quot;
	logic keep_rem;

	// which halves survive for the requested op
	// illegal keeps neither
	always_comb
	begin
		keep_quot = 1'b0;
		keep_rem = 1'b0;
		case (res.op)
			div_pkg::op_quot:
			begin
				keep_quot = 1'b1;
			end

			div_pkg::op_rem:
			begin
				keep_rem = 1'b1;
			end

			div_pkg::op_both:
			begin
				keep_quot = 1'b1;
				keep_rem = 1'b1;
			end

			default:
			begin
				keep_quot = 1'b0;
				keep_rem = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result_valid <= 1'b0;
			quotient <= '0;
			remainder <= '0;
			div_zero <= 1'b0;
			illegal_op <= 1'b0;
		end
		else
		begin
			// one cycle pulse, flags only alongside it
			result_valid <= res.done;
			div_zero <= res.done & res.div_zero;
			illegal_op <= res.done & res.illegal;
			if (res.done)
			begin
				quotient <= keep_quot ? res.quotient : '0;
				remainder <= keep_rem ? res.remainder : '0;
			end
		end
	end

endmodule

// ==== design/div_unit_top.sv ====
module div_unit_top
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [1:0] op,
	input logic [div_pkg::dividend_width-1:0] dividend,
	input logic [div_pkg::divisor_width-1:0] divisor,
	output logic ready,
	output logic result_valid,
	output logic [div_pkg::dividend_width-1:0] quotient,
	output logic [div_pkg::divisor_width-1:0] remainder,
	output logic div_zero,
	output logic illegal_op
);

	logic exec_busy;
	logic decode_busy;

	div_cmd_if cmd_if ();
	div_res_if res_if ();

	// ready drops on acceptance and comes back with the result
	// high straight out of reset, unlike a plain ~busy
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ready <= 1'b1;
		end
		else if (start && ready)
		begin
			ready <= 1'b0;
		end
		else if (res_if.done)
		begin
			ready <= 1'b1;
		end
	end

	// both views agree, either one blocks a new command
	assign decode_busy = ~ready | exec_busy;

	div_decode u_decode
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.dividend(dividend),
		.divisor(divisor),
		.busy(decode_busy),
		.cmd(cmd_if.decode_mp)
	);

	div_execute u_execute
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd_if.execute_mp),
		.res(res_if.execute_mp),
		.busy(exec_busy)
	);

	div_result u_result
	(
		.clk(clk),
		.rst_n(rst_n),
		.res(res_if.result_mp),
		.result_valid(result_valid),
		.quotient(quotient),
		.remainder(remainder),
		.div_zero(div_zero),
		.illegal_op(illegal_op)
	);

endmodule
